//--- project.f
verilog/execPkg.sv
verilog/operandIf.sv
verilog/aluResultIf.sv
verilog/operandStage.sv
verilog/alu32Bit.sv
verilog/hiLoStage.sv
verilog/execUnit.sv
testbench/execUnit_assertions.sv
testbench/execUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module execUnitTb \
    -Mdir obj_dir -o execUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/execUnitSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/execUnitTb.sv
`default_nettype none
`timescale 1ns/1ps

module execUnitTb import execPkg::*; ();

    typedef struct packed {
        word_t result;
        logic  regWrite;
        word_t hi;
        word_t lo;
    } expEntry_t;

    localparam int MAX_CYCLES = 2000; // ~130 ops plus drain gaps

    logic   clk = 1'b0;
    logic   rstN;
    logic   inValid;
    aluOp_t op;
    word_t  a;
    word_t  b;
    shamt_t shamt;
    logic   outValid;
    word_t  result;
    logic   zero;
    logic   regWrite;
    word_t  hi;
    word_t  lo;

    expEntry_t expQ[$];   // Expected outputs in issue order
    dword_t    modelHiLo; // Reference HI/LO pair
    int        errors = 0;
    int        tests  = 0;
    int        cycles = 0;

    execUnit dut_i (
        .clk(clk), .rstN(rstN), .inValid(inValid), .op(op), .a(a), .b(b), .shamt(shamt),
        .outValid(outValid), .result(result), .zero(zero), .regWrite(regWrite),
        .hi(hi), .lo(lo)
    );

    always #50 clk = ~clk; // 100 ns period

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic expEntry_t refModel(aluOp_t opc, word_t x, word_t y, shamt_t sh);
        expEntry_t           e;
        shamt_t              amt;
        longint              sx;
        longint              sy;
        longint unsigned     ux;
        longint unsigned     uy;
        longint              shifted;
        dword_t              prodS;
        sx       = {{32{x[31]}}, x};
        sy       = {{32{y[31]}}, y};
        ux       = {32'h0, x};
        uy       = {32'h0, y};
        prodS    = sx * sy;
        amt      = (opc inside {OP_SLLV, OP_SRLV, OP_SRAV, OP_ROTRV}) ? y[4:0] : sh;
        shifted  = sx >>> amt; // Arithmetic shift on the widened value
        e.result   = 32'h0;
        e.regWrite = 1'b1;
        case (opc)
            OP_ADD, OP_ADDU: e.result = x + y;
            OP_SUB:          e.result = x - y;
            OP_AND:          e.result = x & y;
            OP_OR:           e.result = x | y;
            OP_NOR:          e.result = ~(x | y);
            OP_XOR:          e.result = x ^ y;
            OP_SLL, OP_SLLV: e.result = x << amt;
            OP_SRL, OP_SRLV: e.result = x >> amt;
            OP_SRA, OP_SRAV: e.result = shifted[31:0];
            OP_ROTR, OP_ROTRV: e.result = (x >> amt) | (x << (6'd32 - {1'b0, amt}));
            OP_SLT:          e.result = {31'h0, sx < sy};
            OP_SLTU:         e.result = {31'h0, ux < uy};
            OP_MOVN: begin
                e.result   = x;
                e.regWrite = (y != 32'h0);
            end
            OP_MOVZ: begin
                e.result   = x;
                e.regWrite = (y == 32'h0);
            end
            OP_MUL:          e.result = prodS[31:0];
            OP_SEB:          e.result = y[7] ? {24'hffffff, y[7:0]} : {24'h0, y[7:0]};
            OP_SEH:          e.result = y[15] ? {16'hffff, y[15:0]} : {16'h0, y[15:0]};
            OP_MULT:         modelHiLo = prodS;
            OP_MULTU:        modelHiLo = ux * uy;
            OP_MADD:         modelHiLo = modelHiLo + prodS;
            OP_MSUB:         modelHiLo = modelHiLo - prodS;
            default:         e.regWrite = 1'b0; // Unused code
        endcase
        if (opc inside {OP_MULT, OP_MULTU, OP_MADD, OP_MSUB}) begin
            e.regWrite = 1'b0; // HI/LO only, nothing for rd
        end
        e.hi = modelHiLo[63:32];
        e.lo = modelHiLo[31:0];
        return e;
    endfunction

    task automatic checkValue(input string what, input word_t got, input word_t want);
        if (got !== want) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    // Compare at the falling edge, outputs settled
    always @(negedge clk) begin : outputChecker
        expEntry_t want;
        if (rstN && outValid) begin
            if (expQ.size() == 0) begin
                $display("Error at %0t ns: outValid with no operation outstanding", $time);
                errors++;
            end else begin
                want = expQ.pop_front();
                checkValue("result", result, want.result);
                checkValue("zero", {31'h0, zero}, {31'h0, want.result == 32'h0});
                checkValue("regWrite", {31'h0, regWrite}, {31'h0, want.regWrite});
                checkValue("hi", hi, want.hi);
                checkValue("lo", lo, want.lo);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////////////////////////
    task automatic issue(input aluOp_t opIn, input word_t aIn, input word_t bIn,
                         input shamt_t shIn);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        op      = opIn;
        a       = aIn;
        b       = bIn;
        shamt   = shIn;
        expQ.push_back(refModel(opIn, aIn, bIn, shIn));
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        inValid = 1'b0; // Bubble
    endtask

    task automatic drainAndReport(input string name);
        idleCycle();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic arithLogicTest();
        aluOp_t ops[7] = '{OP_ADD, OP_ADDU, OP_SUB, OP_AND, OP_OR, OP_NOR, OP_XOR};
        issue(OP_ADD, 32'h7fffffff, 32'h1, 5'd0); // Wraps, no trap
        issue(OP_SUB, 32'h0, 32'h1, 5'd0);
        for (int i = 0; i < 6; i++) begin
            foreach (ops[k]) begin
                issue(ops[k], $urandom(), $urandom(), 5'd0); // Back to back
            end
        end
        drainAndReport("arithmetic and logic");
    endtask

    task automatic shiftRotateTest();
        aluOp_t ops[8] = '{OP_SLL, OP_SRL, OP_SRA, OP_ROTR,
                           OP_SLLV, OP_SRLV, OP_SRAV, OP_ROTRV};
        shamt_t amt;
        word_t  x;
        word_t  rnd;
        for (int j = 0; j < 5; j++) begin
            case (j)
                0:       amt = 5'd0;
                1:       amt = 5'd1;
                2:       amt = 5'd31;
                default: amt = shamt_t'($urandom());
            endcase
            foreach (ops[k]) begin
                x      = $urandom();
                x[31]  = j[0] ^ k[2];   // Both signs for SRA and SRAV
                rnd    = $urandom();
                if (k < 4) begin
                    issue(ops[k], x, {rnd[31:5], ~amt}, amt); // b holds a decoy amount
                end else begin
                    issue(ops[k], x, {rnd[31:5], amt}, ~amt); // shamt is the decoy
                end
            end
        end
        drainAndReport("shifts and rotates");
    endtask

    task automatic compareMoveExtendTest();
        issue(OP_SLT, 32'h80000000, 32'h7fffffff, 5'd0);
        issue(OP_SLTU, 32'h80000000, 32'h7fffffff, 5'd0);
        issue(OP_SLT, 32'h7fffffff, 32'h80000000, 5'd0);
        issue(OP_SLTU, 32'h7fffffff, 32'h80000000, 5'd0);
        issue(OP_SLT, 32'hffffffff, 32'h0, 5'd0);
        issue(OP_SLTU, 32'hffffffff, 32'h0, 5'd0);
        issue(OP_SLT, 32'h12345678, 32'h12345678, 5'd0);
        issue(OP_MOVN, 32'hcafe0001, 32'h0, 5'd0); // No write
        issue(OP_MOVN, 32'hcafe0002, 32'h5, 5'd0);
        issue(OP_MOVZ, 32'hcafe0003, 32'h0, 5'd0);
        issue(OP_MOVZ, 32'hcafe0004, 32'h3, 5'd0); // No write
        issue(OP_SEB, 32'h0, 32'habcdef7f, 5'd0);
        issue(OP_SEB, 32'h0, 32'h12345680, 5'd0);
        issue(OP_SEH, 32'h0, 32'hdead7fff, 5'd0);
        issue(OP_SEH, 32'h0, 32'h00018000, 5'd0);
        drainAndReport("compare, move and extend");
    endtask

    task automatic multiplyHiLoTest();
        for (int i = 0; i < 4; i++) begin
            issue(OP_MUL, $urandom(), $urandom(), 5'd0);
        end
        issue(OP_MUL, 32'hfffffffd, 32'h7, 5'd0);
        issue(OP_MULT, 32'hfffffffe, 32'h3, 5'd0);
        issue(OP_MULTU, 32'hffffffff, 32'hffffffff, 5'd0);
        for (int i = 0; i < 6; i++) begin
            issue(OP_MADD, $urandom(), $urandom(), 5'd0); // Accumulate every cycle
        end
        for (int i = 0; i < 6; i++) begin
            issue(OP_MSUB, $urandom(), $urandom(), 5'd0);
        end
        issue(OP_MULT, $urandom(), $urandom(), 5'd0);
        issue(OP_MADD, 32'h80000000, 32'h80000000, 5'd0);
        issue(OP_MSUB, 32'h7fffffff, 32'h80000000, 5'd0);
        drainAndReport("multiply and HI/LO");
    endtask

    task automatic zeroInvalidTest();
        word_t x;
        x = $urandom();
        issue(OP_SUB, x, x, 5'd0);
        idleCycle();
        issue(OP_XOR, x, x, 5'd0);
        issue(OP_AND, 32'hf0f0f0f0, 32'h0f0f0f0f, 5'd0);
        for (int c = 26; c < 32; c++) begin
            issue(aluOp_t'(c), $urandom(), $urandom(), 5'd3);
            if (c[0]) begin
                idleCycle(); // Gap in the issue stream
                idleCycle();
            end
        end
        issue(OP_OR, x, 32'h1, 5'd0); // Nonzero result behind the gaps
        drainAndReport("zero flag and invalid codes");
    endtask

    initial begin
        void'($urandom(32'hb297));
        modelHiLo = '0;
        rstN      = 1'b0;
        inValid   = 1'b0;
        op        = OP_ADD;
        a         = '0;
        b         = '0;
        shamt     = '0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        arithLogicTest();
        shiftRotateTest();
        compareMoveExtendTest();
        multiplyHiLoTest();
        zeroInvalidTest();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/execUnit_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module execUnitAssertions import execPkg::*; (
    input wire logic  clk,
    input wire logic  rstN,
    input wire logic  inValid,
    input wire logic  outValid,
    input wire word_t result,
    input wire logic  zero,
    input wire logic  regWrite
);

    // Three registered stages between issue and output
    latencyForward: assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> ##3 outValid)
        else $error("outValid missing three cycles after inValid");

    latencyBackward: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> $past(inValid, 3))
        else $error("outValid without an issue three cycles before");

    writeNeedsValid: assert property (@(posedge clk) regWrite |-> outValid)
        else $error("regWrite high while outValid low");

    zeroMatches: assert property (@(posedge clk) outValid |-> (zero == (result == 32'h0)))
        else $error("zero flag disagrees with result");

    quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high during reset");

endmodule

bind execUnit execUnitAssertions execUnitAssertions_i (
    .clk(clk), .rstN(rstN), .inValid(inValid), .outValid(outValid),
    .result(result), .zero(zero), .regWrite(regWrite)
);

`default_nettype wire

//--- verilog/execUnit.sv
`default_nettype none
`timescale 1ns/1ps

// Execute section, three stages from issue to writeback strobe
module execUnit import execPkg::*; (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   inValid,
    input  wire aluOp_t op,
    input  wire word_t  a,       // rs
    input  wire word_t  b,       // rt
    input  wire shamt_t shamt,
    output logic        outValid,
    output word_t       result,
    output logic        zero,
    output logic        regWrite,
    output word_t       hi,
    output word_t       lo
);

    operandIf   opBus ();
    aluResultIf aluBus ();

    // Stage 1, operand register
    operandStage operandStage_i (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .op      (op),
        .a       (a),
        .b       (b),
        .shamt   (shamt),
        .opOut   (opBus)
    );

    // Stage 2, ALU and multiplier
    alu32Bit alu32Bit_i (
        .clk    (clk),
        .rstN   (rstN),
        .opIn   (opBus),
        .resOut (aluBus)
    );

    // Stage 3, HI/LO and outputs
    hiLoStage hiLoStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .resIn    (aluBus),
        .outValid (outValid),
        .result   (result),
        .zero     (zero),
        .regWrite (regWrite),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

`default_nettype wire

//--- verilog/hiLoStage.sv
`default_nettype none
`timescale 1ns/1ps

module hiLoStage import execPkg::*; (
    input  wire logic    clk,
    input  wire logic    rstN,
    aluResultIf.consumer resIn,
    output logic         outValid,
    output word_t        result,
    output logic         zero,     // result == 0
    output logic         regWrite,
    output word_t        hi,
    output word_t        lo
);

    dword_t hiLo; // HI in upper word

    ////////////////////////////////////////////////////////////
    // HI/LO pair
    ////////////////////////////////////////////////////////////
    // Accumulate lives here so MADD after MADD needs no bypass
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiLo <= '0;
        end else if (resIn.valid) begin
            case (resIn.hiLoOp)
                HL_WRITE: hiLo <= resIn.product;
                HL_ADD:   hiLo <= hiLo + resIn.product; // 64-bit wrap
                HL_SUB:   hiLo <= hiLo - resIn.product;
                default:  hiLo <= hiLo;                 // HL_NONE
            endcase
        end
    end

    assign hi = hiLo[63:32];
    assign lo = hiLo[31:0];

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            result   <= '0;
            zero     <= 1'b1; // Matches the cleared result
            regWrite <= 1'b0;
        end else begin
            outValid <= resIn.valid;
            result   <= resIn.result;
            zero     <= (resIn.result == '0);
            regWrite <= resIn.valid & resIn.regWrite; // Never without outValid
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu32Bit.sv
`default_nettype none
`timescale 1ns/1ps

module alu32Bit import execPkg::*; (
    input  wire logic    clk,
    input  wire logic    rstN,
    operandIf.consumer   opIn,
    aluResultIf.producer resOut
);

    word_t       nextResult;
    logic        nextRegWrite;
    dword_t      prodSigned;
    dword_t      prodUnsigned;
    logic [63:0] rotWide;     // a twice, shifted for rotate

    ////////////////////////////////////////////////////////////
    // Multiplier and rotator
    ////////////////////////////////////////////////////////////
    // Explicit sign extension keeps the full 64-bit signed product
    assign prodSigned   = $signed({{32{opIn.a[31]}}, opIn.a})
                        * $signed({{32{opIn.b[31]}}, opIn.b});
    assign prodUnsigned = {32'b0, opIn.a} * {32'b0, opIn.b};

    assign rotWide = {opIn.a, opIn.a} >> opIn.amount; // Low half is a rotated right

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////
    always_comb begin
        nextResult   = '0;
        nextRegWrite = 1'b1; // Most ops write rd
        case (opIn.op)
            // No overflow trap, so ADD and ADDU are the same adder
            OP_ADD, OP_ADDU: nextResult = opIn.a + opIn.b;
            OP_SUB:          nextResult = opIn.a - opIn.b;
            OP_AND:          nextResult = opIn.a & opIn.b;
            OP_OR:           nextResult = opIn.a | opIn.b;
            OP_NOR:          nextResult = ~(opIn.a | opIn.b);
            OP_XOR:          nextResult = opIn.a ^ opIn.b;
            OP_SLL, OP_SLLV: nextResult = opIn.a << opIn.amount;
            OP_SRL, OP_SRLV: nextResult = opIn.a >> opIn.amount;
            OP_SRA, OP_SRAV: nextResult = $signed(opIn.a) >>> opIn.amount; // Sign fill
            OP_ROTR, OP_ROTRV: begin
                nextResult = rotWide[31:0];
            end
            OP_SLT:  nextResult = {31'b0, $signed(opIn.a) < $signed(opIn.b)};
            OP_SLTU: nextResult = {31'b0, opIn.a < opIn.b};
            OP_MOVN: begin
                nextResult   = opIn.a;
                nextRegWrite = (opIn.b != '0); // Move only if rt nonzero
            end
            OP_MOVZ: begin
                nextResult   = opIn.a;
                nextRegWrite = (opIn.b == '0);
            end
            OP_MUL:  nextResult = prodSigned[31:0]; // Low word to rd
            OP_SEB:  nextResult = {{24{opIn.b[7]}}, opIn.b[7:0]};
            OP_SEH:  nextResult = {{16{opIn.b[15]}}, opIn.b[15:0]};
            OP_MULT, OP_MULTU, OP_MADD, OP_MSUB: begin
                // Product goes to HI/LO, nothing for rd
                nextRegWrite = 1'b0;
            end
            default: begin
                nextRegWrite = 1'b0; // Invalid code, result stays 0
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resOut.valid    <= 1'b0;
            resOut.result   <= '0;
            resOut.regWrite <= 1'b0;
            resOut.hiLoOp   <= HL_NONE;
        end else begin
            resOut.valid    <= opIn.valid;
            resOut.result   <= opIn.valid ? nextResult : '0; // Bubble carries 0
            resOut.regWrite <= opIn.valid & nextRegWrite;
            resOut.hiLoOp   <= opIn.hiLoOp;
        end
    end

    // Only MULTU wants the unsigned product
    always_ff @(posedge clk) begin
        resOut.product <= (opIn.op == OP_MULTU) ? prodUnsigned : prodSigned;
    end

endmodule

`default_nettype wire

//--- verilog/operandStage.sv
`default_nettype none
`timescale 1ns/1ps

module operandStage import execPkg::*; (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    inValid, // Issue strobe
    input  wire aluOp_t  op,
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire shamt_t  shamt,   // From the instruction word
    operandIf.producer   opOut
);

    shamt_t  amountSel;
    hiLoOp_t hiLoKind;

    // Variable shifts take the amount from rt
    always_comb begin
        case (op)
            OP_SLLV, OP_SRLV, OP_SRAV, OP_ROTRV: amountSel = b[4:0];
            default:                             amountSel = shamt;
        endcase
    end

    // Accumulate kind decoded once here
    always_comb begin
        case (op)
            OP_MULT, OP_MULTU: hiLoKind = HL_WRITE;
            OP_MADD:           hiLoKind = HL_ADD;
            OP_MSUB:           hiLoKind = HL_SUB;
            default:           hiLoKind = HL_NONE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opOut.valid  <= 1'b0;
            opOut.hiLoOp <= HL_NONE;
        end else begin
            opOut.valid  <= inValid;
            opOut.hiLoOp <= inValid ? hiLoKind : HL_NONE; // Idle slot never touches HI/LO
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin // Payload held between issues
            opOut.op     <= op;
            opOut.a      <= a;
            opOut.b      <= b;
            opOut.amount <= amountSel;
        end
    end

endmodule

`default_nettype wire

//--- verilog/aluResultIf.sv
`default_nettype none
`timescale 1ns/1ps

// ALU stage to HI/LO stage
interface aluResultIf import execPkg::*; ();

    logic    valid;    // No ready, data lives for this cycle only
    word_t   result;
    logic    regWrite;
    hiLoOp_t hiLoOp;
    dword_t  product;  // Signed or unsigned by opcode

    modport producer (
        output valid, result, regWrite, hiLoOp, product
    );

    modport consumer (
        input valid, result, regWrite, hiLoOp, product
    );

endinterface

`default_nettype wire

//--- verilog/operandIf.sv
`default_nettype none
`timescale 1ns/1ps

// Operand stage to ALU stage, one operation per valid cycle
interface operandIf import execPkg::*; ();

    logic    valid;  // Qualifies everything below
    aluOp_t  op;
    word_t   a;
    word_t   b;
    shamt_t  amount; // Already picked from shamt or b
    hiLoOp_t hiLoOp; // HL_NONE unless multiply class

    modport producer (
        output valid, op, a, b, amount, hiLoOp
    );

    modport consumer (
        input valid, op, a, b, amount, hiLoOp
    );

endinterface

`default_nettype wire

//--- verilog/execPkg.sv
`default_nettype none

package execPkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths, fixed by the MIPS instruction set
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;   // One register operand or result
    typedef logic [63:0] dword_t;  // Product or HI/LO pair, HI on top
    typedef logic [4:0]  shamt_t;  // Shift amount
    typedef logic [4:0]  aluOp_t;  // Operation code
    typedef logic [1:0]  hiLoOp_t; // Accumulate kind

    ////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////
    // Low codes keep the classic ALU control encoding
    localparam aluOp_t OP_ADD   = 5'd0;
    localparam aluOp_t OP_ADDU  = 5'd1;
    localparam aluOp_t OP_SUB   = 5'd2;
    localparam aluOp_t OP_MULT  = 5'd3;
    localparam aluOp_t OP_MULTU = 5'd4;
    localparam aluOp_t OP_AND   = 5'd5;
    localparam aluOp_t OP_OR    = 5'd6;
    localparam aluOp_t OP_NOR   = 5'd7;
    localparam aluOp_t OP_XOR   = 5'd8;
    localparam aluOp_t OP_SLL   = 5'd9;
    localparam aluOp_t OP_SRL   = 5'd10;
    localparam aluOp_t OP_SLLV  = 5'd11;
    localparam aluOp_t OP_SLT   = 5'd12;
    localparam aluOp_t OP_MOVN  = 5'd13;
    localparam aluOp_t OP_MOVZ  = 5'd14;
    localparam aluOp_t OP_ROTRV = 5'd15;
    localparam aluOp_t OP_SRA   = 5'd16;
    localparam aluOp_t OP_SRAV  = 5'd17;
    localparam aluOp_t OP_SLTU  = 5'd18;
    localparam aluOp_t OP_MUL   = 5'd19;
    localparam aluOp_t OP_MADD  = 5'd20;
    localparam aluOp_t OP_MSUB  = 5'd21;
    localparam aluOp_t OP_SRLV  = 5'd22; // Upper codes added with the shift set
    localparam aluOp_t OP_ROTR  = 5'd23;
    localparam aluOp_t OP_SEB   = 5'd24;
    localparam aluOp_t OP_SEH   = 5'd25; // 26..31 unused, treated as invalid

    // HI/LO accumulate kinds
    localparam hiLoOp_t HL_NONE  = 2'd0; // HI/LO untouched
    localparam hiLoOp_t HL_WRITE = 2'd1; // Load product (MULT, MULTU)
    localparam hiLoOp_t HL_ADD   = 2'd2; // HI/LO plus product (MADD)
    localparam hiLoOp_t HL_SUB   = 2'd3; // HI/LO minus product (MSUB)

endpackage

`default_nettype wire
